// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= keypad_display_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+.
key_pkg.sv
disp_pkg.sv
key_decode.sv
digit_editor.sv
seg_scan.sv
keypad_display_top.sv
keypad_display_checker.sv
keypad_display_tb.sv

// ==== digit_editor.sv ====
`timescale 1ns/1ps

`include "keypad_cfg.svh"

module digit_editor import key_pkg::*, disp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     key_valid,
    input  key_evt_t key_evt,
    output frame_t   frame,
    output logic     committed
);

    digit_idx_t cursor;
    digit_idx_t cursor_next;
    frame_t     shadow;
    seg_t       glyph;
    logic       is_digit;
    logic       is_next;
    logic       is_commit;

    assign is_digit  = key_valid && (key_evt.cls == KEY_DIGIT);
    assign is_next   = key_valid && (key_evt.cls == KEY_NEXT);
    assign is_commit = key_valid && (key_evt.cls == KEY_COMMIT);

    // wrap after the last digit
    assign cursor_next = (cursor == LAST_DIGIT) ? '0 : cursor + 1'b1;

    assign glyph = glyph_of(key_evt.value);

    always_ff @(posedge clk) begin
        if (rst) begin
            cursor <= '0;
        end else if (is_next) begin
            cursor <= cursor_next;
        end
    end

    // shadow buffer edited one digit at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            shadow <= FRAME_BLANK;
        end else if (is_digit) begin
            shadow[cursor] <= glyph;  // overwrites whatever was there
        end
    end

    // shadow and cursor survive a commit so editing goes on
    always_ff @(posedge clk) begin
        if (rst) begin
            frame     <= FRAME_BLANK;
            committed <= 1'b0;
        end else begin
            committed <= is_commit;
            if (is_commit) begin
                frame <= shadow;
            end
        end
    end

endmodule

// ==== disp_pkg.sv ====
`include "keypad_cfg.svh"

package disp_pkg;

    // segment order is a..g from bit 6 down to bit 0
    typedef logic [6:0] seg_t;

    // digit 0 lives in the low seven bits
    typedef seg_t [`NUM_DIGITS-1:0] frame_t;

    typedef logic [`NUM_DIGITS-1:0] digit_sel_t;

    typedef logic [$clog2(`NUM_DIGITS)-1:0] digit_idx_t;

    localparam seg_t       SEG_BLANK   = 7'b000_0000;
    localparam frame_t     FRAME_BLANK = '0;
    localparam digit_idx_t LAST_DIGIT  = digit_idx_t'(`NUM_DIGITS - 1);

    function automatic seg_t glyph_of(input logic [3:0] value);
        seg_t glyph;
        case (value)
            4'd0:    glyph = 7'b1111110;
            4'd1:    glyph = 7'b0110000;
            4'd2:    glyph = 7'b1101101;
            4'd3:    glyph = 7'b1111001;
            4'd4:    glyph = 7'b0110011;
            4'd5:    glyph = 7'b1011011;
            4'd6:    glyph = 7'b1011111;
            4'd7:    glyph = 7'b1110010;
            4'd8:    glyph = 7'b1111111;
            4'd9:    glyph = 7'b1111011;
            default: glyph = SEG_BLANK; // out of range shows nothing
        endcase
        return glyph;
    endfunction

endpackage

// ==== key_decode.sv ====
`timescale 1ns/1ps

`include "keypad_cfg.svh"

module key_decode import key_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`NUM_KEYS-1:0] keypad,
    output logic                 key_valid,
    output key_evt_t             key_evt
);

    logic [`NUM_KEYS-1:0] prev_keypad;
    logic                 single_key;
    logic                 prev_idle;
    logic                 press;
    key_evt_t             evt_d;

    // exactly one bit set: non-zero and clearing the lowest bit leaves zero
    assign single_key = (keypad != '0) && ((keypad & (keypad - 1'b1)) == '0);
    assign prev_idle  = (prev_keypad == '0);
    assign press      = single_key && prev_idle;

    // classify the pressed bit
    always_comb begin
        evt_d = KEY_EVT_NONE;
        if (keypad[KEY_BIT_NEXT]) begin
            evt_d.cls = KEY_NEXT;
        end else if (keypad[KEY_BIT_COMMIT]) begin
            evt_d.cls = KEY_COMMIT;
        end else begin
            // bits 0..8 carry digits 1..9, bit 9 leaves value at 0
            for (int i = 0; i < KEY_BIT_ZERO; i++) begin
                if (keypad[i]) begin
                    evt_d.value = 4'(i + 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_keypad <= '0;
            key_valid   <= 1'b0;
        end else begin
            prev_keypad <= keypad;  // held key or chord blocks re-trigger
            key_valid   <= press;
        end
    end

    // payload, only looked at while key_valid is high
    always_ff @(posedge clk) begin
        if (press) begin
            key_evt <= evt_d;
        end
    end

endmodule

// ==== key_pkg.sv ====
package key_pkg;

    // bit positions of the non-numeric keys on the keypad bus
    localparam int KEY_BIT_ZERO   = 9;  // digit 0, digits 1..9 sit below it
    localparam int KEY_BIT_COMMIT = 10; // '*'
    localparam int KEY_BIT_NEXT   = 11; // '#'

    // largest value a digit key carries
    localparam logic [3:0] KEY_VALUE_MAX = 4'd9;

    typedef enum logic [1:0] {
        KEY_DIGIT  = 2'd0,
        KEY_NEXT   = 2'd1,
        KEY_COMMIT = 2'd2
    } key_class_t;

    // one decoded key press, value only meaningful for KEY_DIGIT
    typedef struct packed {
        key_class_t cls;
        logic [3:0] value;
    } key_evt_t;

    localparam key_evt_t KEY_EVT_NONE = '{cls: KEY_DIGIT, value: 4'd0};

endpackage

// ==== keypad_cfg.svh ====
`ifndef KEYPAD_CFG_SVH
`define KEYPAD_CFG_SVH

// display digits, cursor wraps at this count
`define NUM_DIGITS 8

// clocks per digit during the multiplexed scan
`define SCAN_DIV 4

`define NUM_KEYS 12

`endif

// ==== keypad_display_checker.sv ====
`timescale 1ns/1ps

module keypad_display_checker import disp_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       key_valid,
    input logic       committed,
    input frame_t     frame,
    input frame_t     shadow,
    input digit_sel_t digit_sel
);

    int fail_cnt = 0;  // failed assertions so far

    strobe_one_cycle: assert property (
        @(posedge clk) disable iff (rst) key_valid |=> !key_valid
    ) else begin
        $error("key_valid stayed high for two cycles");
        fail_cnt++;
    end

    sel_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(digit_sel)
    ) else begin
        $error("digit_sel has more than one bit set");
        fail_cnt++;
    end

    // commit copies the shadow buffer as it stood on the commit edge
    commit_copies_shadow: assert property (
        @(posedge clk) disable iff (rst) committed |-> (frame == $past(shadow))
    ) else begin
        $error("frame does not match the shadow buffer after a commit");
        fail_cnt++;
    end

    quiet_in_reset: assert property (
        @(posedge clk) rst |=> (!key_valid && !committed && digit_sel == '0 && frame == '0)
    ) else begin
        $error("output active while in reset");
        fail_cnt++;
    end

endmodule

bind keypad_display_top keypad_display_checker chk_i (
    .clk       (clk),
    .rst       (rst),
    .key_valid (key_valid),
    .committed (committed),
    .frame     (frame),
    .shadow    (u_digit_editor.shadow),
    .digit_sel (digit_sel)
);

// ==== keypad_display_tb.sv ====
`timescale 1ns/1ps

`include "keypad_cfg.svh"

module keypad_display_tb import disp_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYC    = 2;
    localparam int MAX_STEP_CYC = 20;  // drive, hold, release, commit wait, settle
    localparam int SCAN_CYC     = `NUM_DIGITS * `SCAN_DIV + 2;
    localparam int MARGIN_NS    = 2000;

    localparam logic [`NUM_KEYS-1:0] KEY_ZERO = `NUM_KEYS'(1) << 9;
    localparam logic [`NUM_KEYS-1:0] KEY_STAR = `NUM_KEYS'(1) << 10;
    localparam logic [`NUM_KEYS-1:0] KEY_HASH = `NUM_KEYS'(1) << 11;

    typedef struct packed {
        logic [`NUM_KEYS-1:0] pattern;
        logic [2:0]           hold;  // 0 picks 1..4 at random
        logic                 exp_commit;
    } step_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic [`NUM_KEYS-1:0] keypad;
    frame_t               frame;
    logic                 committed;
    seg_t                 seg;
    digit_sel_t           digit_sel;

    step_t steps[$];
    logic  table_ready = 1'b0;
    int    cycle       = 0;
    int    commit_cnt  = 0;
    int    commit_cyc  = 0;
    int    exp_commits = 0;

    // reference model of the editor
    seg_t glyph_tbl [10] = '{7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011,
                             7'b1011011, 7'b1011111, 7'b1110010, 7'b1111111, 7'b1111011};
    frame_t     m_shadow = '0;
    frame_t     m_frame  = '0;
    digit_idx_t m_cursor = '0;

    keypad_display_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .keypad    (keypad),
        .frame     (frame),
        .committed (committed),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // count commit pulses and note when they came
    always @(posedge clk) begin
        if (!rst && committed) begin
            commit_cyc = cycle;
            commit_cnt = commit_cnt + 1;
        end
        if (dut_i.chk_i.fail_cnt != 0) begin
            abort_run("a concurrent assertion in the checker failed");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_frame(input string name, input frame_t got, input frame_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic check_scan(input seg_t got_seg, input seg_t exp_seg,
                              input digit_sel_t got_sel, input digit_sel_t exp_sel);
        if (got_sel !== exp_sel) begin
            abort_run($sformatf("ERR %0t digit_sel got %b exp %b", $time, got_sel, exp_sel));
        end
        if (got_seg !== exp_seg) begin
            abort_run($sformatf("ERR %0t seg got %b exp %b", $time, got_seg, exp_seg));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %0t %s got %0d exp %0d", $time, name, got, exp));
        end
    endtask

    function automatic logic [`NUM_KEYS-1:0] digit_key(input int d);
        return (d == 0) ? KEY_ZERO : `NUM_KEYS'(1) << (d - 1);
    endfunction

    function automatic void add_step(input logic [`NUM_KEYS-1:0] p, input logic [2:0] h,
                                     input logic c);
        steps.push_back('{pattern: p, hold: h, exp_commit: c});
    endfunction

    function automatic void build_table();
        int order[6] = '{7, 8, 9, 0, 5, 4};
        add_step(digit_key(1), 3'd0, 1'b0);
        add_step(KEY_HASH, 3'd0, 1'b0);
        add_step(digit_key(2), 3'd0, 1'b0);
        add_step(KEY_HASH, 3'd0, 1'b0);
        add_step(digit_key(3), 3'd0, 1'b0);
        add_step(KEY_STAR, 3'd1, 1'b1);
        add_step(KEY_HASH, 3'd4, 1'b0);  // held key moves the cursor once
        add_step(digit_key(4), 3'd0, 1'b0);
        add_step(digit_key(1) | digit_key(2), 3'd2, 1'b0);
        add_step(KEY_HASH | digit_key(5), 3'd1, 1'b0);
        add_step(KEY_STAR, 3'd0, 1'b1);
        // five bring the cursor from 3 to 0 and nine more land on 1
        for (int i = 0; i < 14; i++) begin
            add_step(KEY_HASH, 3'd0, 1'b0);
        end
        add_step(digit_key(6), 3'd0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            add_step(KEY_HASH, 3'd0, 1'b0);
            add_step(digit_key(order[i]), 3'd0, 1'b0);
        end
        add_step(KEY_STAR, 3'd3, 1'b1);
    endfunction

    function automatic void model_key(input logic [`NUM_KEYS-1:0] pattern);
        int b;
        b = 0;
        if ($countones(pattern) != 1) begin
            return;  // idle or chord
        end
        while (!pattern[b]) begin
            b++;
        end
        if (b < 10) begin
            m_shadow[m_cursor] = glyph_tbl[(b + 1) % 10];  // bit 9 is digit 0
        end else if (b == 11) begin
            m_cursor = (m_cursor == digit_idx_t'(`NUM_DIGITS - 1)) ? '0 : m_cursor + 1'b1;
        end else begin
            m_frame = m_shadow;
        end
    endfunction

    task automatic apply_step(input step_t s);
        int hold;
        int press_cyc;
        int waited;
        hold = (s.hold == 3'd0) ? 1 + int'($urandom % 4) : int'(s.hold);
        @(posedge clk);
        keypad <= s.pattern;
        @(posedge clk);  // press edge
        press_cyc = cycle;
        repeat (hold - 1) @(posedge clk);
        keypad <= '0;
        @(posedge clk);
        model_key(s.pattern);
        if (s.exp_commit) begin
            exp_commits++;
            waited = 0;
            while (commit_cnt < exp_commits && waited < 8) begin
                @(negedge clk);
                waited++;
            end
            if (commit_cnt < exp_commits) begin
                abort_run("no committed pulse followed the commit key");
            end
            check_count("commit latency", commit_cyc - press_cyc, 2);
            @(negedge clk);
            check_frame("frame", frame, m_frame);
        end
        repeat (2) @(negedge clk);
        check_count("committed pulses", commit_cnt, exp_commits);
    endtask

    task automatic scan_window();
        digit_sel_t seen;
        digit_sel_t sel;
        int         idx;
        seen = '0;
        repeat (`NUM_DIGITS * `SCAN_DIV) begin
            @(negedge clk);
            sel = digit_sel;
            if (sel != '0) begin
                idx = 0;
                while (!sel[idx]) begin
                    idx++;
                end
                check_scan(seg, m_frame[idx], sel, digit_sel_t'(1) << idx);
                seen[idx] = 1'b1;
            end
        end
        if (seen != '1) begin
            abort_run("the scan did not select every digit");
        end
    endtask

    initial begin
        int waited;
        rst    = 1'b1;
        keypad = '0;
        void'($urandom(9));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_frame("frame", frame, m_frame);
        check_count("committed", int'(committed), 0);
        waited = 0;
        while (digit_sel == '0 && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        check_scan(seg, m_frame[0], digit_sel, digit_sel_t'(1));
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        scan_window();
        if (dut_i.chk_i.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("the checker reported an assertion failure");
        end
    end

    // watchdog sized from the table length
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (RESET_CYC + steps.size() * MAX_STEP_CYC + SCAN_CYC) * CLK_PERIOD + MARGIN_NS;
        #(limit_ns);
        abort_run("watchdog timeout, the run did not finish in time");
    end

endmodule

// ==== keypad_display_top.sv ====
`timescale 1ns/1ps

`include "keypad_cfg.svh"

module keypad_display_top import key_pkg::*, disp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`NUM_KEYS-1:0] keypad,
    output frame_t               frame,
    output logic                 committed,
    output seg_t                 seg,
    output digit_sel_t           digit_sel
);

    logic     key_valid;
    key_evt_t key_evt;

    key_decode u_key_decode (
        .clk       (clk),
        .rst       (rst),
        .keypad    (keypad),
        .key_valid (key_valid),
        .key_evt   (key_evt)
    );

    digit_editor u_digit_editor (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_evt   (key_evt),
        .frame     (frame),
        .committed (committed)
    );

    // scan reads the same frame that leaves the top
    seg_scan u_seg_scan (
        .clk       (clk),
        .rst       (rst),
        .frame     (frame),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

endmodule

// ==== seg_scan.sv ====
`timescale 1ns/1ps

`include "keypad_cfg.svh"

module seg_scan import disp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  frame_t     frame,
    output seg_t       seg,
    output digit_sel_t digit_sel
);

    localparam int DIV_W = $clog2(`SCAN_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCAN_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    digit_idx_t       idx;
    logic             step;

    assign step = (div_cnt == DIV_LAST);

    // divider and digit index
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            idx     <= '0;
        end else if (step) begin
            div_cnt <= '0;
            idx     <= (idx == LAST_DIGIT) ? '0 : idx + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // select and glyph come from the same index on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            digit_sel <= '0;
        end else begin
            digit_sel <= digit_sel_t'(1) << idx;
        end
    end

    always_ff @(posedge clk) begin
        seg <= frame[idx];
    end

endmodule
